// ==== cfo_phase_accum.sv ====
module cfo_phase_accum import receiver_pkg::*; (
    input  logic                          clk_i,
    input  logic                          reset_ni,

    input  cfo_mode_e                     cfo_mode_i,
    input  logic signed [CFO_PHASE_W-1:0] cfo_inc_i,
    input  logic                          cfo_valid_i,

    input  logic                          sample_valid_i,
    output logic        [CFO_PHASE_W-1:0] phase_o
);

    // accumulated increment, each new estimate is relative to the last
    logic signed [CFO_PHASE_W-1:0] inc_q;
    logic        [CFO_PHASE_W-1:0] phase_q;

    // ------------------------------------------------------------------
    // increment register
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            inc_q <= '0;
        end else if (cfo_mode_i == CFO_MANUAL) begin
            inc_q <= '0;
        end else if (cfo_valid_i) begin
            inc_q <= inc_q - cfo_inc_i;
        end
    end

    // ------------------------------------------------------------------
    // phase accumulator
    // ------------------------------------------------------------------
    // advances once per valid sample, wraps modulo 2^CFO_PHASE_W
    // the old increment applies when both strobes coincide
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            phase_q <= '0;
        end else if (cfo_mode_i == CFO_MANUAL) begin
            phase_q <= '0;
        end else if (sample_valid_i) begin
            phase_q <= phase_q + $unsigned(inc_q);
        end
    end

    // current sample sees the phase before its own update
    assign phase_o = phase_q;

endmodule

// ==== complex_mixer.sv ====
module complex_mixer import receiver_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_ni,

    input  tagged_iq_t sample_i,
    input  iq_t        rot_i,
    input  logic       valid_i,

    output tagged_iq_t mixed_o,
    output logic       mixed_valid_o
);

    localparam int PROD_W = 2 * IQ_W;
    localparam int SUM_W  = PROD_W + 1;

    // clamp to the signed IQ_W range
    function automatic logic signed [IQ_W-1:0] saturate(input logic signed [SUM_W-1:0] v);
        logic [SUM_W-IQ_W:0] top;
        top = v[SUM_W-1:IQ_W-1];
        if ((&top) || !(|top)) begin
            saturate = v[IQ_W-1:0];
        end else if (v[SUM_W-1]) begin
            saturate = {1'b1, {(IQ_W-1){1'b0}}};
        end else begin
            saturate = {1'b0, {(IQ_W-1){1'b1}}};
        end
    endfunction

    // ------------------------------------------------------------------
    // stage 1, partial products
    // ------------------------------------------------------------------
    logic signed [PROD_W-1:0] prod_rr_q;
    logic signed [PROD_W-1:0] prod_ii_q;
    logic signed [PROD_W-1:0] prod_ri_q;
    logic signed [PROD_W-1:0] prod_ir_q;
    logic [SAMPLE_ID_W-1:0]   id_q;
    logic                     valid_q;

    always_ff @(posedge clk_i) begin
        prod_rr_q <= sample_i.iq.re * rot_i.re;
        prod_ii_q <= sample_i.iq.im * rot_i.im;
        prod_ri_q <= sample_i.iq.re * rot_i.im;
        prod_ir_q <= sample_i.iq.im * rot_i.re;
        id_q      <= sample_i.id;
    end

    // ------------------------------------------------------------------
    // stage 2, sum, shift by the rotator fraction, saturate
    // ------------------------------------------------------------------
    logic signed [SUM_W-1:0] sum_re;
    logic signed [SUM_W-1:0] sum_im;

    assign sum_re = (prod_rr_q - prod_ii_q) >>> ROT_FRAC_W;
    assign sum_im = (prod_ri_q + prod_ir_q) >>> ROT_FRAC_W;

    always_ff @(posedge clk_i) begin
        mixed_o.iq.re <= saturate(sum_re);
        mixed_o.iq.im <= saturate(sum_im);
        mixed_o.id    <= id_q;
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            valid_q       <= 1'b0;
            mixed_valid_o <= 1'b0;
        end else begin
            valid_q       <= valid_i;
            mixed_valid_o <= valid_q;
        end
    end

endmodule

// ==== power_detector.sv ====
module power_detector import receiver_pkg::*; (
    input  logic                   clk_i,
    input  logic                   reset_ni,

    input  tagged_iq_t             mixed_i,
    input  logic                   mixed_valid_i,
    input  logic [31:0]            threshold_i,

    output logic                   peak_o,
    output logic [SAMPLE_ID_W-1:0] peak_id_o
);

    localparam int SQ_W = 2 * IQ_W;

    logic signed [SQ_W-1:0] re_sq;
    logic signed [SQ_W-1:0] im_sq;
    logic [POWER_W-1:0]     power;
    logic                   above;

    // squares are never negative, so the sum fits unsigned
    assign re_sq = mixed_i.iq.re * mixed_i.iq.re;
    assign im_sq = mixed_i.iq.im * mixed_i.iq.im;
    assign power = POWER_W'($unsigned(re_sq)) + POWER_W'($unsigned(im_sq));

    // strictly above, equal power does not fire
    assign above = mixed_valid_i && (power > POWER_W'(threshold_i));

    // ------------------------------------------------------------------
    // peak pulse and id of the last peak
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            peak_o    <= 1'b0;
            peak_id_o <= '0;
        end else begin
            peak_o <= above;
            if (above) begin
                peak_id_o <= mixed_i.id;
            end
        end
    end

endmodule

// ==== receiver_front.f ====
receiver_pkg.sv
cfo_phase_accum.sv
rotator_lut.sv
complex_mixer.sv
power_detector.sv
receiver_front.sv
tb_receiver_front.sv

// ==== receiver_front.sv ====
module receiver_front import receiver_pkg::*; (
    input  logic                          clk_i,
    input  logic                          reset_ni,

    input  iq_t                           sample_i,
    input  logic                          sample_valid_i,

    input  logic signed [CFO_PHASE_W-1:0] cfo_inc_i,
    input  logic                          cfo_valid_i,
    input  cfo_mode_e                     cfo_mode_i,

    input  logic        [31:0]            threshold_i,

    output tagged_iq_t                    mixed_o,
    output logic                          mixed_valid_o,
    output logic                          peak_detected_o,
    output logic        [SAMPLE_ID_W-1:0] peak_id_o
);

    logic [SAMPLE_ID_W-1:0] sample_cnt;
    tagged_iq_t             sample_d;
    logic [CFO_PHASE_W-1:0] phase;
    iq_t                    rot;
    logic                   rot_valid;

    // ------------------------------------------------------------------
    // sample tagging
    // ------------------------------------------------------------------
    // counts valid samples, wraps at 2^SAMPLE_ID_W
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            sample_cnt <= '0;
        end else if (sample_valid_i) begin
            sample_cnt <= sample_cnt + 1'b1;
        end
    end

    // one register to meet the rotator
    always_ff @(posedge clk_i) begin
        sample_d.iq <= sample_i;
        sample_d.id <= sample_cnt;
    end

    // ------------------------------------------------------------------
    // cfo correction chain
    // ------------------------------------------------------------------
    cfo_phase_accum cfo_phase_accum_i (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .cfo_mode_i     (cfo_mode_i),
        .cfo_inc_i      (cfo_inc_i),
        .cfo_valid_i    (cfo_valid_i),
        .sample_valid_i (sample_valid_i),
        .phase_o        (phase)
    );

    rotator_lut rotator_lut_i (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .phase_i       (phase),
        .phase_valid_i (sample_valid_i),
        .rot_o         (rot),
        .rot_valid_o   (rot_valid)
    );

    complex_mixer complex_mixer_i (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .sample_i      (sample_d),
        .rot_i         (rot),
        .valid_i       (rot_valid),
        .mixed_o       (mixed_o),
        .mixed_valid_o (mixed_valid_o)
    );

    power_detector power_detector_i (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .mixed_i       (mixed_o),
        .mixed_valid_i (mixed_valid_o),
        .threshold_i   (threshold_i),
        .peak_o        (peak_detected_o),
        .peak_id_o     (peak_id_o)
    );

endmodule

// ==== receiver_front_cases.txt ====
# name mode cfo_valid cfo_inc sample_valid re im threshold exp_re exp_im exp_det
# mode 0 is auto, 1 is manual; expected columns count only when sample_valid is 1
reset_idle 0 0 0 0 0 0 100000000 0 0 0
reset_idle 0 0 0 0 0 0 100000000 0 0 0
reset_idle 0 0 0 0 0 0 100000000 0 0 0
manual_cfo 1 1 -50000 1 1000 -1000 100000000 999 -1000 0
manual 1 0 0 1 10001 0 100000000 10000 0 0
manual 1 0 0 1 10002 0 100000000 10001 0 1
manual 1 0 0 1 -20000 12345 100000000 -19999 12344 1
auto_cfo 0 1 -16384 1 3000 -4000 100000000 2999 -4000 0
auto_cfo 0 1 -32768 1 12000 0 100000000 11999 0 1
auto 0 0 0 1 8000 0 100000000 7960 784 0
auto_gap 0 0 0 0 0 0 100000000 0 0 0
auto_gap 0 0 0 0 0 0 100000000 0 0 0
auto 0 0 0 1 1000 2000 100000000 158 2230 0
auto 0 0 0 1 -5000 3000 100000000 -5768 -853 0
auto 0 0 0 1 20000 0 100000000 11110 16628 1
auto 0 0 0 1 0 10000 100000000 -9570 2902 1
auto 0 0 0 1 7000 -3000 100000000 2999 6999 0
auto 0 0 0 1 -6000 -6000 100000000 7483 -4000 0
auto_cfo 0 1 -147456 1 10000 0 100000000 -5556 8314 0
auto 0 0 0 1 0 -8000 100000000 5074 6183 0
auto 0 0 0 1 16000 16000 100000000 -6569 -21653 1
auto 0 0 0 1 -2000 500 100000000 301 2039 0
auto 0 0 0 1 30000 -30000 100000000 19998 -32768 1
auto_wrap 0 0 0 1 4000 0 100000000 2537 3091 0
sat_clear 1 0 0 0 0 0 100000000 0 0 0
sat_cfo 0 1 -131072 0 0 0 100000000 0 0 0
saturate 0 0 0 1 -1000 2000 100000000 -1000 1999 0
saturate 0 0 0 1 32767 32767 100000000 0 32767 1
saturate 0 0 0 1 -32768 -32768 100000000 32766 -32766 1
saturate 0 0 0 1 -32768 32767 100000000 0 -32768 1
thr_clear 1 0 0 0 0 0 100000000 0 0 0
threshold 1 0 0 1 0 10001 100000000 0 10000 0
threshold 1 0 0 1 6000 8001 100000000 5999 8000 0
threshold 1 0 0 1 6002 8001 100000000 6001 8000 1
threshold 1 0 0 0 0 0 100000000 0 0 0
threshold 1 0 0 1 -6000 -8000 100000000 -6000 -8000 0
threshold 1 0 0 1 -6000 -8001 100000000 -6000 -8001 1
tail_idle 1 0 0 0 0 0 100000000 0 0 0
tail_idle 1 0 0 0 0 0 100000000 0 0 0

// ==== receiver_pkg.sv ====
package receiver_pkg;

    // ------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------
    localparam int IQ_W        = 16;
    localparam int CFO_PHASE_W = 20;
    localparam int LUT_IDX_W   = 6;
    localparam int ROT_FRAC_W  = 14;
    localparam int SAMPLE_ID_W = 16;
    localparam int POWER_W     = 33;

    // top two lut bits select the quadrant
    localparam int QUAD_W      = 2;
    localparam int QIDX_W      = LUT_IDX_W - QUAD_W;
    localparam int QUARTER_LEN = 2 ** QIDX_W + 1;

    // ------------------------------------------------------------------
    // quarter wave cosine, 0 .. pi/2 in 16 steps, scaled by 2^14 - 1
    // ------------------------------------------------------------------
    localparam logic signed [IQ_W-1:0] QUARTER_COS [QUARTER_LEN] = '{
        16'sd16383,
        16'sd16304,
        16'sd16068,
        16'sd15678,
        16'sd15136,
        16'sd14449,
        16'sd13622,
        16'sd12664,
        16'sd11585,
        16'sd10393,
        16'sd9102,
        16'sd7723,
        16'sd6270,
        16'sd4756,
        16'sd3196,
        16'sd1606,
        16'sd0
    };

    // ------------------------------------------------------------------
    // types
    // ------------------------------------------------------------------
    typedef struct packed {
        logic signed [IQ_W-1:0] re;
        logic signed [IQ_W-1:0] im;
    } iq_t;

    typedef struct packed {
        iq_t                    iq;
        logic [SAMPLE_ID_W-1:0] id;
    } tagged_iq_t;

    // manual mode parks the rotator at phase zero
    typedef enum logic {
        CFO_AUTO   = 1'b0,
        CFO_MANUAL = 1'b1
    } cfo_mode_e;

endpackage

// ==== rotator_lut.sv ====
module rotator_lut import receiver_pkg::*; (
    input  logic                   clk_i,
    input  logic                   reset_ni,

    input  logic [CFO_PHASE_W-1:0] phase_i,
    input  logic                   phase_valid_i,

    output iq_t                    rot_o,
    output logic                   rot_valid_o
);

    logic [LUT_IDX_W-1:0] angle;
    logic [QUAD_W-1:0]    quad;
    logic [QIDX_W:0]      idx;
    logic [QIDX_W:0]      idx_mirror;

    logic signed [IQ_W-1:0] t_fwd;
    logic signed [IQ_W-1:0] t_rev;
    iq_t                    rot_d;

    // top phase bits, quadrant and index inside the quadrant
    assign angle      = phase_i[CFO_PHASE_W-1 -: LUT_IDX_W];
    assign quad       = angle[LUT_IDX_W-1 -: QUAD_W];
    assign idx        = {1'b0, angle[QIDX_W-1:0]};
    assign idx_mirror = (QIDX_W+1)'(QUARTER_LEN - 1) - idx;

    assign t_fwd = QUARTER_COS[idx];
    assign t_rev = QUARTER_COS[idx_mirror];

    // quadrant folding
    always_comb begin
        case (quad)
            2'd0: begin
                rot_d.re = t_fwd;
                rot_d.im = t_rev;
            end
            2'd1: begin
                rot_d.re = -t_rev;
                rot_d.im = t_fwd;
            end
            2'd2: begin
                rot_d.re = -t_fwd;
                rot_d.im = -t_rev;
            end
            default: begin
                rot_d.re = t_rev;
                rot_d.im = -t_fwd;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            rot_valid_o <= 1'b0;
        end else begin
            rot_valid_o <= phase_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        rot_o <= rot_d;
    end

endmodule

// ==== tb_receiver_front.sv ====
module tb_receiver_front import receiver_pkg::*; ();

    localparam int NAME_LEN      = 16;
    // negedges from driving a sample to seeing it on mixed_o
    localparam int MIX_LATENCY   = 3;
    localparam int MAX_LINES     = 1000;
    localparam int DRAIN_TIMEOUT = 50;

    typedef struct packed {
        logic [8*NAME_LEN-1:0]  name;
        logic [31:0]            due;
        iq_t                    data;
        logic [SAMPLE_ID_W-1:0] id;
        logic                   det;
    } expect_t;

    logic                          clk;
    logic                          reset_n;
    iq_t                           sample;
    logic                          sample_valid;
    logic signed [CFO_PHASE_W-1:0] cfo_inc;
    logic                          cfo_valid;
    cfo_mode_e                     cfo_mode;
    logic [31:0]                   threshold;
    tagged_iq_t                    mixed;
    logic                          mixed_valid;
    logic                          peak_detected;
    logic [SAMPLE_ID_W-1:0]        peak_id;

    expect_t               mix_q[$];
    expect_t               peak_q[$];
    int                    cycle;
    int                    sample_id;
    logic [8*NAME_LEN-1:0] cur_name;

    receiver_front DUT (
        .clk_i           (clk),
        .reset_ni        (reset_n),
        .sample_i        (sample),
        .sample_valid_i  (sample_valid),
        .cfo_inc_i       (cfo_inc),
        .cfo_valid_i     (cfo_valid),
        .cfo_mode_i      (cfo_mode),
        .threshold_i     (threshold),
        .mixed_o         (mixed),
        .mixed_valid_o   (mixed_valid),
        .peak_detected_o (peak_detected),
        .peak_id_o       (peak_id)
    );

    always #4 clk = ~clk;

    // ------------------------------------------------------------------
    // error reporting
    // ------------------------------------------------------------------
    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic report_mismatch(input logic [8*NAME_LEN-1:0] name, input string field,
                                   input int expected, input int actual);
        $display("MISMATCH test %0s %0s expected %0d actual %0d",
                 name, field, expected, actual);
        abort_run();
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        abort_run();
    endtask

    // ------------------------------------------------------------------
    // output checks, once per falling edge
    // ------------------------------------------------------------------
    task automatic check_mixed();
        expect_t e;
        if (mix_q.size() > 0 && mix_q[0].due == cycle) begin
            e = mix_q.pop_front();
            assert (mixed_valid === 1'b1)
                else report_mismatch(e.name, "mixed_valid_o", 1, mixed_valid);
            assert (mixed.iq.re === e.data.re)
                else report_mismatch(e.name, "mixed_o.re", e.data.re, mixed.iq.re);
            assert (mixed.iq.im === e.data.im)
                else report_mismatch(e.name, "mixed_o.im", e.data.im, mixed.iq.im);
            assert (mixed.id === e.id)
                else report_mismatch(e.name, "mixed_o.id", e.id, mixed.id);
        end else begin
            assert (mixed_valid === 1'b0)
                else report_mismatch(cur_name, "mixed_valid_o", 0, mixed_valid);
        end
    endtask

    task automatic check_peak();
        expect_t e;
        if (peak_q.size() > 0 && peak_q[0].due == cycle) begin
            e = peak_q.pop_front();
            assert (peak_detected === e.det)
                else report_mismatch(e.name, "peak_detected_o", e.det, peak_detected);
            if (e.det) begin
                assert (peak_id === e.id)
                    else report_mismatch(e.name, "peak_id_o", e.id, peak_id);
            end
        end else begin
            assert (peak_detected === 1'b0)
                else report_mismatch(cur_name, "peak_detected_o", 0, peak_detected);
        end
    endtask

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------
    task automatic drive_line(input int mode, input int cv, input int inc, input int sv,
                              input int re, input int im, input int thr);
        cfo_mode     = (mode != 0) ? CFO_MANUAL : CFO_AUTO;
        cfo_valid    = (cv != 0);
        cfo_inc      = inc[CFO_PHASE_W-1:0];
        sample_valid = (sv != 0);
        sample.re    = re[IQ_W-1:0];
        sample.im    = im[IQ_W-1:0];
        threshold    = thr;
    endtask

    // ids are counted here, independent of the DUT counter
    task automatic push_expect(input logic [8*NAME_LEN-1:0] name, input int re, input int im,
                               input int det);
        expect_t e;
        e.name    = name;
        e.due     = cycle + MIX_LATENCY;
        e.data.re = re[IQ_W-1:0];
        e.data.im = im[IQ_W-1:0];
        e.id      = sample_id[SAMPLE_ID_W-1:0];
        e.det     = (det != 0);
        mix_q.push_back(e);
        e.due     = cycle + MIX_LATENCY + 1;
        peak_q.push_back(e);
        sample_id = sample_id + 1;
    endtask

    initial begin
        int                    fd;
        int                    n;
        int                    lines;
        int                    wait_cnt;
        logic                  done;
        logic [8*256-1:0]      line;
        logic [8*NAME_LEN-1:0] tok;
        logic [8*NAME_LEN-1:0] name_v;
        int                    f_mode;
        int                    f_cv;
        int                    f_inc;
        int                    f_sv;
        int                    f_re;
        int                    f_im;
        int                    f_thr;
        int                    f_ere;
        int                    f_eim;
        int                    f_det;

        clk       = 1'b0;
        reset_n   = 1'b0;
        drive_line(0, 0, 0, 0, 0, 0, 0);
        cycle     = 0;
        sample_id = 0;
        cur_name  = "reset";

        fd = $fopen("receiver_front_cases.txt", "r");
        if (fd == 0) begin
            report_failure("could not open receiver_front_cases.txt");
        end

        repeat (10) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        // one data line per falling edge, comment lines start with #
        lines = 0;
        done  = 1'b0;
        while (!done) begin
            n = $fgets(line, fd);
            if (n == 0) begin
                done = 1'b1;
            end else begin
                lines = lines + 1;
                if (lines > MAX_LINES) begin
                    report_failure("cases file is longer than the line limit");
                end
                n = $sscanf(line, "%s", tok);
                if (n == 1 && tok != "#") begin
                    n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d", name_v,
                                f_mode, f_cv, f_inc, f_sv, f_re, f_im, f_thr,
                                f_ere, f_eim, f_det);
                    if (n != 11) begin
                        report_failure("malformed line in receiver_front_cases.txt");
                    end
                    check_mixed();
                    check_peak();
                    cur_name = name_v;
                    drive_line(f_mode, f_cv, f_inc, f_sv, f_re, f_im, f_thr);
                    if (f_sv != 0) begin
                        push_expect(name_v, f_ere, f_eim, f_det);
                    end
                    @(negedge clk);
                    cycle = cycle + 1;
                end
            end
        end
        $fclose(fd);

        // drain what is still in flight
        cfo_valid    = 1'b0;
        sample_valid = 1'b0;
        wait_cnt     = 0;
        while ((mix_q.size() > 0 || peak_q.size() > 0) && wait_cnt < DRAIN_TIMEOUT) begin
            check_mixed();
            check_peak();
            @(negedge clk);
            cycle    = cycle + 1;
            wait_cnt = wait_cnt + 1;
        end

        if (mix_q.size() > 0 || peak_q.size() > 0) begin
            report_failure("timeout while waiting for the last outputs");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule
